// ==== src/rv_core_pkg.sv ====
// Shared widths, opcodes, control encodings and instruction formats; referenced by scoped name.
package rv_core_pkg;

  localparam int unsigned XLEN       = 64;
  localparam int unsigned INST_W     = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NUM_REGS   = 2 ** REG_ADDR_W;

  localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;
  localparam logic [XLEN-1:0] INST_BYTES = 64'd4; // pc step and jal link offset

  // major opcodes
  localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
  localparam logic [6:0] OPC_OP     = 7'b011_0011;
  localparam logic [6:0] OPC_LUI    = 7'b011_0111;
  localparam logic [6:0] OPC_AUIPC  = 7'b001_0111;
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;

  localparam logic [2:0] F3_ADD     = 3'b000; // addi, add, sub
  localparam logic [2:0] F3_PRIV    = 3'b000; // ecall/ebreak group
  localparam logic [6:0] F7_ADD     = 7'b000_0000;
  localparam logic [6:0] F7_SUB     = 7'b010_0000;
  localparam logic [11:0] IMM_EBREAK = 12'h001;

  typedef enum logic [1:0] {
    ALU_ADD    = 2'd0,
    ALU_SUB    = 2'd1,
    ALU_PASS_B = 2'd2, // lui
    ALU_NONE   = 2'd3
  } alu_op_e;

  typedef enum logic {
    A_REG = 1'b0,
    A_PC  = 1'b1
  } a_sel_e;

  typedef enum logic [1:0] {
    B_REG  = 2'd0,
    B_IMM  = 2'd1,
    B_FOUR = 2'd2 // jal link value
  } b_sel_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // u and j share the layout, only the immediate bit order differs
  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } uj_fmt_t;

  typedef union packed {
    r_fmt_t  r_fmt;
    i_fmt_t  i_fmt;
    uj_fmt_t uj_fmt;
  } inst_u;

endpackage

// ==== src/rv_dec_if.sv ====
// Decoded instruction controls passed from the decode unit to the register file, ALU and top level.
interface rv_dec_if;

  logic [rv_core_pkg::REG_ADDR_W-1:0] ra;
  logic [rv_core_pkg::REG_ADDR_W-1:0] rb;
  logic [rv_core_pkg::REG_ADDR_W-1:0] rd;
  logic [rv_core_pkg::XLEN-1:0]       imm;
  rv_core_pkg::a_sel_e                a_sel;
  rv_core_pkg::b_sel_e                b_sel;
  rv_core_pkg::alu_op_e               alu_op;
  logic                               wen;
  logic                               is_jal;
  logic                               is_ebreak;
  logic                               is_illegal;

  modport dec (
    output ra, rb, rd, imm, a_sel, b_sel, alu_op,
    output wen, is_jal, is_ebreak, is_illegal
  );

  modport exe (
    input a_sel, b_sel, alu_op, imm
  );

  modport rf (
    input ra, rb, rd
  );

endinterface

// ==== src/rv_idu.sv ====
// Instruction decode unit; turns one instruction word into register indices, immediate and controls.
module rv_idu (
  input  rv_core_pkg::inst_u i_inst,
  rv_dec_if.dec              dec
);

  logic [rv_core_pkg::XLEN-1:0] imm_i;
  logic [rv_core_pkg::XLEN-1:0] imm_u;
  logic [rv_core_pkg::XLEN-1:0] imm_j;
  logic [19:0]                  imm20;
  logic [6:0]                   opcode;
  logic                         ebreak_match;

  assign opcode = i_inst.r_fmt.opcode;
  assign imm20  = i_inst.uj_fmt.imm20;

  // register indices come straight from the r-type slots
  assign dec.ra = i_inst.r_fmt.rs1;
  assign dec.rb = i_inst.r_fmt.rs2;
  assign dec.rd = i_inst.r_fmt.rd;

  assign imm_i = {{52{i_inst.i_fmt.imm12[11]}}, i_inst.i_fmt.imm12};
  assign imm_u = {{32{imm20[19]}}, imm20, 12'b0};
  // j layout inside imm20: [19]=imm[20], [18:9]=imm[10:1], [8]=imm[11], [7:0]=imm[19:12]
  assign imm_j = {{44{imm20[19]}}, imm20[7:0], imm20[8], imm20[18:9], 1'b0};

  // ebreak is a fixed word, every field has to match
  assign ebreak_match = (i_inst.i_fmt.imm12  == rv_core_pkg::IMM_EBREAK) &&
                        (i_inst.i_fmt.rs1    == '0) &&
                        (i_inst.i_fmt.funct3 == rv_core_pkg::F3_PRIV) &&
                        (i_inst.i_fmt.rd     == '0);

  always_comb begin
    dec.imm        = '0;
    dec.a_sel      = rv_core_pkg::A_REG;
    dec.b_sel      = rv_core_pkg::B_REG;
    dec.alu_op     = rv_core_pkg::ALU_NONE;
    dec.wen        = 1'b0;
    dec.is_jal     = 1'b0;
    dec.is_ebreak  = 1'b0;
    dec.is_illegal = 1'b0;

    case (opcode)
      rv_core_pkg::OPC_OP_IMM: begin
        if (i_inst.i_fmt.funct3 == rv_core_pkg::F3_ADD) begin // addi
          dec.imm    = imm_i;
          dec.b_sel  = rv_core_pkg::B_IMM;
          dec.alu_op = rv_core_pkg::ALU_ADD;
          dec.wen    = 1'b1;
        end else begin
          dec.is_illegal = 1'b1;
        end
      end

      rv_core_pkg::OPC_OP: begin
        if (i_inst.r_fmt.funct3 != rv_core_pkg::F3_ADD) begin
          dec.is_illegal = 1'b1;
        end else if (i_inst.r_fmt.funct7 == rv_core_pkg::F7_ADD) begin
          dec.alu_op = rv_core_pkg::ALU_ADD;
          dec.wen    = 1'b1;
        end else if (i_inst.r_fmt.funct7 == rv_core_pkg::F7_SUB) begin
          dec.alu_op = rv_core_pkg::ALU_SUB;
          dec.wen    = 1'b1;
        end else begin
          dec.is_illegal = 1'b1; // other funct7, e.g. mul
        end
      end

      rv_core_pkg::OPC_LUI: begin
        dec.imm    = imm_u;
        dec.b_sel  = rv_core_pkg::B_IMM;
        dec.alu_op = rv_core_pkg::ALU_PASS_B;
        dec.wen    = 1'b1;
      end

      rv_core_pkg::OPC_AUIPC: begin
        dec.imm    = imm_u;
        dec.a_sel  = rv_core_pkg::A_PC;
        dec.b_sel  = rv_core_pkg::B_IMM;
        dec.alu_op = rv_core_pkg::ALU_ADD;
        dec.wen    = 1'b1;
      end

      rv_core_pkg::OPC_JAL: begin
        dec.imm    = imm_j;                // used by the target adder in the top
        dec.a_sel  = rv_core_pkg::A_PC;
        dec.b_sel  = rv_core_pkg::B_FOUR;  // alu makes the link value
        dec.alu_op = rv_core_pkg::ALU_ADD;
        dec.wen    = 1'b1;
        dec.is_jal = 1'b1;
      end

      rv_core_pkg::OPC_SYSTEM: begin
        if (ebreak_match) begin
          dec.is_ebreak = 1'b1;
        end else begin
          dec.is_illegal = 1'b1; // ecall, csr ops
        end
      end

      default: begin
        dec.is_illegal = 1'b1;
      end
    endcase
  end

endmodule

// ==== src/rv_regfile.sv ====
// Integer register file; two asynchronous read ports, one clocked write port, x0 hardwired to zero.
module rv_regfile (
  input  logic                         i_clk,
  input  logic                         i_arst_n,
  rv_dec_if.rf                         rf,
  input  logic                         i_we,
  input  logic [rv_core_pkg::XLEN-1:0] i_wdata,
  output logic [rv_core_pkg::XLEN-1:0] o_rdata_a,
  output logic [rv_core_pkg::XLEN-1:0] o_rdata_b
);

  // no storage behind x0
  logic [rv_core_pkg::XLEN-1:0] regs [1:rv_core_pkg::NUM_REGS-1];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 1; i < rv_core_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (rf.rd != '0)) begin // writes to x0 dropped
      regs[rf.rd] <= i_wdata;
    end
  end

  always_comb begin
    if (rf.ra == '0) begin
      o_rdata_a = '0;
    end else begin
      o_rdata_a = regs[rf.ra];
    end
  end

  always_comb begin
    if (rf.rb == '0) begin
      o_rdata_b = '0;
    end else begin
      o_rdata_b = regs[rf.rb];
    end
  end

endmodule

// ==== src/rv_alu.sv ====
// Execute stage ALU; picks operands from registers, pc, immediate or four and adds, subtracts or passes.
module rv_alu (
  rv_dec_if.exe                        exe,
  input  logic [rv_core_pkg::XLEN-1:0] i_rs1,
  input  logic [rv_core_pkg::XLEN-1:0] i_rs2,
  input  logic [rv_core_pkg::XLEN-1:0] i_pc,
  output logic [rv_core_pkg::XLEN-1:0] o_result
);

  logic [rv_core_pkg::XLEN-1:0] op_a;
  logic [rv_core_pkg::XLEN-1:0] op_b;

  always_comb begin
    case (exe.a_sel)
      rv_core_pkg::A_PC: op_a = i_pc;  // auipc, jal
      default:           op_a = i_rs1;
    endcase
  end

  always_comb begin
    case (exe.b_sel)
      rv_core_pkg::B_REG:  op_b = i_rs2;
      rv_core_pkg::B_IMM:  op_b = exe.imm;
      rv_core_pkg::B_FOUR: op_b = rv_core_pkg::INST_BYTES;
      default:             op_b = '0;
    endcase
  end

  always_comb begin
    case (exe.alu_op)
      rv_core_pkg::ALU_ADD:    o_result = op_a + op_b;
      rv_core_pkg::ALU_SUB:    o_result = op_a - op_b;
      rv_core_pkg::ALU_PASS_B: o_result = op_b;
      default:                 o_result = '0; // ebreak, illegal
    endcase
  end

endmodule

// ==== src/rv_core_top.sv ====
// Single-cycle RV64 execution slice top; takes strobed instructions and reports writeback and pc.
module rv_core_top (
  input  logic        i_clk,
  input  logic        i_arst_n,
  input  logic        i_inst_valid,
  input  logic [31:0] i_inst,
  output logic        o_wb_valid,
  output logic [4:0]  o_wb_rd,
  output logic [63:0] o_wb_data,
  output logic [63:0] o_pc,
  output logic        o_ebreak,
  output logic        o_illegal
);

  rv_core_pkg::inst_u           inst;
  logic [rv_core_pkg::XLEN-1:0] pc_q;
  logic [rv_core_pkg::XLEN-1:0] pc_next;
  logic [rv_core_pkg::XLEN-1:0] pc_seq;
  logic [rv_core_pkg::XLEN-1:0] pc_jal;
  logic [rv_core_pkg::XLEN-1:0] rs1_data;
  logic [rv_core_pkg::XLEN-1:0] rs2_data;
  logic [rv_core_pkg::XLEN-1:0] alu_result;
  logic                         rf_we;

  rv_dec_if dec_if ();

  assign inst = i_inst;

  rv_idu u_idu (
    .i_inst (inst),
    .dec    (dec_if)
  );

  rv_regfile u_regfile (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .rf        (dec_if),
    .i_we      (rf_we),
    .i_wdata   (alu_result),
    .o_rdata_a (rs1_data),
    .o_rdata_b (rs2_data)
  );

  rv_alu u_alu (
    .exe      (dec_if),
    .i_rs1    (rs1_data),
    .i_rs2    (rs2_data),
    .i_pc     (pc_q),
    .o_result (alu_result)
  );

  assign rf_we = i_inst_valid & dec_if.wen; // commit only on a strobe

  // separate target adder, the alu produces the jal link
  assign pc_seq = pc_q + rv_core_pkg::INST_BYTES;
  assign pc_jal = pc_q + dec_if.imm;

  always_comb begin
    if (dec_if.is_jal) begin
      pc_next = pc_jal;
    end else if (dec_if.is_ebreak) begin
      pc_next = pc_q; // halt point
    end else begin
      pc_next = pc_seq; // illegal ones step over too
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pc_q       <= rv_core_pkg::RESET_PC;
      o_wb_valid <= 1'b0;
      o_ebreak   <= 1'b0;
      o_illegal  <= 1'b0;
    end else begin
      if (i_inst_valid) begin
        pc_q <= pc_next;
      end
      o_wb_valid <= i_inst_valid & dec_if.wen; // pulses for rd == 0 as well
      o_ebreak   <= i_inst_valid & dec_if.is_ebreak;
      o_illegal  <= i_inst_valid & dec_if.is_illegal;
    end
  end

  // writeback payload, qualified by o_wb_valid
  always_ff @(posedge i_clk) begin
    if (rf_we) begin
      o_wb_rd   <= dec_if.rd;
      o_wb_data <= alu_result;
    end
  end

  assign o_pc = pc_q;

endmodule

// ==== verification/rv_core_assertions.sv ====
// Bound checker for the RV64 slice; a shadow register file and pc predict each output one cycle on.
module rv_core_assertions (
  input logic        i_clk,
  input logic        i_arst_n,
  input logic        i_inst_valid,
  input logic [31:0] i_inst,
  input logic        o_wb_valid,
  input logic [4:0]  o_wb_rd,
  input logic [63:0] o_wb_data,
  input logic [63:0] o_pc,
  input logic        o_ebreak,
  input logic        o_illegal
);

  int unsigned fail_count = 0;

  logic [63:0] shadow_regs [0:31];
  logic [63:0] exp_pc;
  logic        exp_wb_valid;
  logic [4:0]  exp_wb_rd;
  logic [63:0] exp_wb_data;
  logic        exp_ebreak;
  logic        exp_illegal;
  logic [6:0]  opc;
  logic [4:0]  rd;
  logic [63:0] src1;
  logic [63:0] src2;
  logic [63:0] imm_i;
  logic [63:0] imm_u;
  logic [63:0] imm_j;
  logic        m_write;
  logic        m_ebreak;
  logic        m_illegal;
  logic [63:0] m_data;
  logic [63:0] m_pc;

  assign opc   = i_inst[6:0];
  assign rd    = i_inst[11:7];
  assign src1  = shadow_regs[i_inst[19:15]]; // entry 0 is never written
  assign src2  = shadow_regs[i_inst[24:20]];
  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    m_write   = (i_inst != 32'h0010_0073);
    m_ebreak  = 1'b0;
    m_illegal = 1'b0;
    m_data    = '0;
    m_pc      = exp_pc + 64'd4;
    if (opc == rv_core_pkg::OPC_OP_IMM && i_inst[14:12] == 3'b000) begin
      m_data = src1 + imm_i;
    end else if (opc == rv_core_pkg::OPC_OP && i_inst[14:12] == 3'b000
                 && i_inst[31:25] == 7'h00) begin
      m_data = src1 + src2;
    end else if (opc == rv_core_pkg::OPC_OP && i_inst[14:12] == 3'b000
                 && i_inst[31:25] == 7'h20) begin
      m_data = src1 - src2;
    end else if (opc == rv_core_pkg::OPC_LUI) begin
      m_data = imm_u;
    end else if (opc == rv_core_pkg::OPC_AUIPC) begin
      m_data = exp_pc + imm_u;
    end else if (opc == rv_core_pkg::OPC_JAL) begin
      m_data = exp_pc + 64'd4; // link
      m_pc   = exp_pc + imm_j;
    end else if (!m_write) begin
      m_ebreak = 1'b1;
      m_pc     = exp_pc;
    end else begin
      m_write   = 1'b0;
      m_illegal = 1'b1;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < 32; i++) begin
        shadow_regs[i] <= '0;
      end
      exp_pc       <= rv_core_pkg::RESET_PC;
      exp_wb_valid <= 1'b0;
      exp_wb_rd    <= '0;
      exp_wb_data  <= '0;
      exp_ebreak   <= 1'b0;
      exp_illegal  <= 1'b0;
    end else begin
      exp_wb_valid <= i_inst_valid & m_write;
      exp_ebreak   <= i_inst_valid & m_ebreak;
      exp_illegal  <= i_inst_valid & m_illegal;
      if (i_inst_valid) begin
        exp_pc <= m_pc;
        if (m_write) begin
          exp_wb_rd   <= rd;
          exp_wb_data <= m_data;
        end
        if (m_write && rd != 5'd0) begin
          shadow_regs[rd] <= m_data;
        end
      end
    end
  end

  a_pc: assert property (@(posedge i_clk) disable iff (!i_arst_n) o_pc == exp_pc)
    else begin
      fail_count++;
      $error("FAILED t=%0t o_pc got %h expected %h", $time, $sampled(o_pc), $sampled(exp_pc));
    end
  a_wb_valid: assert property (@(posedge i_clk) disable iff (!i_arst_n) o_wb_valid == exp_wb_valid)
    else begin
      fail_count++;
      $error("FAILED t=%0t o_wb_valid got %b expected %b", $time, $sampled(o_wb_valid),
             $sampled(exp_wb_valid));
    end
  a_wb_rd: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                            o_wb_valid |-> o_wb_rd == exp_wb_rd)
    else begin
      fail_count++;
      $error("FAILED t=%0t o_wb_rd got %0d expected %0d", $time, $sampled(o_wb_rd),
             $sampled(exp_wb_rd));
    end
  a_wb_data: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                              o_wb_valid |-> o_wb_data == exp_wb_data)
    else begin
      fail_count++;
      $error("FAILED t=%0t o_wb_data got %h expected %h", $time, $sampled(o_wb_data),
             $sampled(exp_wb_data));
    end
  a_ebreak: assert property (@(posedge i_clk) disable iff (!i_arst_n) o_ebreak == exp_ebreak)
    else begin
      fail_count++;
      $error("FAILED t=%0t o_ebreak got %b expected %b", $time, $sampled(o_ebreak),
             $sampled(exp_ebreak));
    end
  a_illegal: assert property (@(posedge i_clk) disable iff (!i_arst_n) o_illegal == exp_illegal)
    else begin
      fail_count++;
      $error("FAILED t=%0t o_illegal got %b expected %b", $time, $sampled(o_illegal),
             $sampled(exp_illegal));
    end

endmodule

// ==== verification/rv_core_tb.sv ====
// Testbench for the RV64 slice; strobes random instructions while the bound checker compares results.
module rv_core_tb;

  localparam int N_MIX      = 48;
  localparam int N_UPPER    = 8;
  localparam int N_JAL      = 8;
  localparam int STROBES    = 1 + N_MIX + 5 + 2 * N_UPPER + 2 * N_JAL + 7;
  localparam int MAX_CYCLES = 2 * STROBES + 100;
  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

  logic        clk;
  logic        arst_n;
  logic        inst_valid;
  logic [31:0] inst_word;
  logic        wb_valid;
  logic [4:0]  wb_rd;
  logic [63:0] wb_data;
  logic [63:0] pc;
  logic        ebreak;
  logic        illegal;
  logic [31:0] lfsr_state;
  int          cycles = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int unsigned errs_at_start;

  rv_core_top dut0 (
    .i_clk        (clk),
    .i_arst_n     (arst_n),
    .i_inst_valid (inst_valid),
    .i_inst       (inst_word),
    .o_wb_valid   (wb_valid),
    .o_wb_rd      (wb_rd),
    .o_wb_data    (wb_data),
    .o_pc         (pc),
    .o_ebreak     (ebreak),
    .o_illegal    (illegal)
  );

  bind rv_core_top rv_core_assertions u_chk (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .o_wb_valid   (o_wb_valid),
    .o_wb_rd      (o_wb_rd),
    .o_wb_data    (o_wb_data),
    .o_pc         (o_pc),
    .o_ebreak     (o_ebreak),
    .o_illegal    (o_illegal)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("run stopped after %0d cycles without reaching the end", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [4:0] rd);
    return {f7, rs2, rs1, 3'b000, rd, rv_core_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] enc_addi(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [4:0] rd);
    return {imm, rs1, 3'b000, rd, rv_core_pkg::OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_core_pkg::OPC_JAL};
  endfunction

  task automatic strobe(input logic [31:0] w);
    inst_word  = w;
    inst_valid = 1'b1;
    @(negedge clk);
    inst_valid = 1'b0;
  endtask

  task automatic end_test(input string name);
    int unsigned errs;
    repeat (2) @(negedge clk); // last result lands one cycle after its strobe
    errs = dut0.u_chk.fail_count - errs_at_start;
    if (errs == 0) begin
      tests_passed++;
      $display("%0t test %s passed", $time, name);
    end else begin
      tests_failed++;
      $display("%0t test %s failed with %0d assertion errors", $time, name, errs);
    end
    errs_at_start = dut0.u_chk.fail_count;
  endtask

  initial begin
    logic [4:0] r;
    lfsr_state    = 32'ha704_4708;
    arst_n        = 1'b0;
    inst_valid    = 1'b0;
    inst_word     = '0;
    errs_at_start = 0;
    repeat (2) @(negedge clk);
    arst_n = 1'b1;

    @(negedge clk);
    strobe(enc_r(7'h00, 5'd0, 5'd0, 5'd1)); // add x1, x0, x0
    end_test("reset state");

    for (int i = 0; i < N_MIX; i++) begin
      case (2'(rand_bits(2)))
        2'd1:    strobe(enc_r(7'h00, 5'(rand_bits(5)), 5'(rand_bits(5)), 5'(rand_bits(5))));
        2'd2:    strobe(enc_r(7'h20, 5'(rand_bits(5)), 5'(rand_bits(5)), 5'(rand_bits(5))));
        default: strobe(enc_addi(12'(rand_bits(12)), 5'(rand_bits(5)), 5'(rand_bits(5))));
      endcase
      if (rand_bits(1)) begin
        @(negedge clk);
      end
    end
    end_test("addi add sub mix");

    strobe(enc_addi(12'(rand_bits(12)) | 12'd1, 5'd0, 5'd0));
    strobe(enc_addi(12'(rand_bits(12)), 5'(rand_bits(5)), 5'd0));
    strobe(enc_r(7'h00, 5'd0, 5'd0, 5'd3));
    strobe(enc_r(7'h20, 5'd0, 5'd0, 5'd4));
    strobe(enc_addi(12'd7, 5'd0, 5'd6));
    end_test("writes to x0");

    for (int i = 0; i < N_UPPER; i++) begin
      strobe({20'(rand_bits(20)), 5'(rand_bits(5)), rv_core_pkg::OPC_LUI});
      strobe({20'(rand_bits(20)), 5'(rand_bits(5)), rv_core_pkg::OPC_AUIPC});
    end
    end_test("lui auipc");

    for (int i = 0; i < N_JAL; i++) begin
      r = 5'(rand_bits(5));
      strobe(enc_jal({20'(rand_bits(20)), 1'b0}, r));
      strobe(enc_r(7'h00, 5'd0, r, 5'(rand_bits(5)))); // read back the link
    end
    end_test("jal");

    r = 5'(rand_bits(5)) | 5'd1;
    strobe(enc_addi(12'h5a5, 5'd0, r)); // known nonzero value in r
    strobe(EBREAK_WORD);
    strobe({20'(rand_bits(20)), r, 7'b000_1011}); // custom opcode
    strobe(enc_r(7'h00, 5'd0, r, 5'd9));
    strobe(enc_r(7'h01, 5'(rand_bits(5)), 5'(rand_bits(5)), r)); // mul funct7
    strobe(enc_r(7'h00, 5'd0, r, 5'd10));
    strobe(EBREAK_WORD);
    end_test("ebreak and illegal");

    $display("tests passed %0d, tests failed %0d, assertion errors %0d",
             tests_passed, tests_failed, dut0.u_chk.fail_count);
    if (tests_failed == 0 && dut0.u_chk.fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== rv_core.f ====
src/rv_core_pkg.sv
src/rv_dec_if.sv
src/rv_idu.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_core_top.sv
verification/rv_core_assertions.sv
verification/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - files:
      - src/rv_core_pkg.sv
      - src/rv_dec_if.sv
      - src/rv_idu.sv
      - src/rv_regfile.sv
      - src/rv_alu.sv
      - src/rv_core_top.sv
  - target: simulation
    files:
      - verification/rv_core_assertions.sv
      - verification/rv_core_tb.sv
